/* source/vgaPkg.sv */
/*
 * Shared video types and constants
 * pixel position struct, RGB332 colour union,
 * default 640x480 timing and colour levels
 */
`default_nettype none

package vgaPkg;

	// current scan position, counted over the whole line and frame
	typedef struct packed
	{
		logic [10:0] x;
		logic [10:0] y;
	} pixelPos;

	// RGB332 colour split into its channels
	typedef struct packed
	{
		logic [2:0] red;
		logic [2:0] green;
		logic [1:0] blue;
	} rgbFields;

	// one colour byte, seen raw at the port and as channels by the drawers
	typedef union packed
	{
		logic [7:0] raw;
		rgbFields fields;
	} rgbPixel;

	// default 640x480 timing, in pixels and lines
	localparam int DEF_H_ACTIVE = 640;
	localparam int DEF_H_FRONT = 16;
	localparam int DEF_H_SYNC = 96;
	localparam int DEF_H_BACK = 48;
	localparam int DEF_V_ACTIVE = 480;
	localparam int DEF_V_FRONT = 10;
	localparam int DEF_V_SYNC = 2;
	localparam int DEF_V_BACK = 33;

	localparam logic [2:0] DARK_COLOR = 3'b111; // channel fully on
	localparam logic [2:0] LIGHT_COLOR = 3'b000; // channel off

	// square fill, red 0 green 1 blue 3
	localparam rgbPixel SQUARE_COLOR = 8'b000_001_11;

endpackage

`default_nettype wire

/* source/vgaSyncGen.sv */
/*
 * Raster sync generator
 * pixel and line counters, active flag, start of frame strobe,
 * sync pulses retimed to the draw pipeline
 */
`default_nettype none

module vgaSyncGen
#(
	parameter int hActive = vgaPkg::DEF_H_ACTIVE,
	parameter int hFront = vgaPkg::DEF_H_FRONT,
	parameter int hSync = vgaPkg::DEF_H_SYNC,
	parameter int hBack = vgaPkg::DEF_H_BACK,
	parameter int vActive = vgaPkg::DEF_V_ACTIVE,
	parameter int vFront = vgaPkg::DEF_V_FRONT,
	parameter int vSync = vgaPkg::DEF_V_SYNC,
	parameter int vBack = vgaPkg::DEF_V_BACK
)
(
	input logic clk,
	input logic resetN,
	output vgaPkg::pixelPos pos,
	output logic active,
	output logic startOfFrame,
	output logic hSyncN,
	output logic vSyncN
);

	localparam logic [10:0] H_LAST = 11'(hActive + hFront + hSync + hBack - 1);
	localparam logic [10:0] V_LAST = 11'(vActive + vFront + vSync + vBack - 1);
	localparam logic [10:0] H_SYNC_START = 11'(hActive + hFront);
	localparam logic [10:0] H_SYNC_END = 11'(hActive + hFront + hSync); // first pixel after pulse
	localparam logic [10:0] V_SYNC_START = 11'(vActive + vFront);
	localparam logic [10:0] V_SYNC_END = 11'(vActive + vFront + vSync);

	logic [10:0] xCnt;
	logic [10:0] yCnt;
	logic hSyncRaw; // decoded sync, active high
	logic vSyncRaw;
	logic [1:0] hSyncPipe; // two stages to line up with rgb
	logic [1:0] vSyncPipe;

	always_ff @(posedge clk or negedge resetN)
	begin
		if (!resetN)
		begin
			xCnt <= '0;
			yCnt <= '0;
		end
		else if (xCnt == H_LAST)
		begin
			xCnt <= '0;
			yCnt <= (yCnt == V_LAST) ? 11'd0 : yCnt + 11'd1; // next line or wrap frame
		end
		else
			xCnt <= xCnt + 11'd1;
	end

	assign hSyncRaw = (xCnt >= H_SYNC_START) && (xCnt < H_SYNC_END);
	assign vSyncRaw = (yCnt >= V_SYNC_START) && (yCnt < V_SYNC_END);

	// pipe holds active low levels, so reset fills it with ones
	always_ff @(posedge clk or negedge resetN)
	begin
		if (!resetN)
		begin
			hSyncPipe <= 2'b11;
			vSyncPipe <= 2'b11;
		end
		else
		begin
			hSyncPipe <= {hSyncPipe[0], ~hSyncRaw};
			vSyncPipe <= {vSyncPipe[0], ~vSyncRaw};
		end
	end

	assign pos.x = xCnt;
	assign pos.y = yCnt;
	assign active = (xCnt < 11'(hActive)) && (yCnt < 11'(vActive));
	assign startOfFrame = (xCnt == 11'd0) && (yCnt == 11'd0); // one clock per frame
	assign hSyncN = hSyncPipe[1];
	assign vSyncN = vSyncPipe[1];

endmodule

`default_nettype wire

/* source/backGroundDraw.sv */
/*
 * Background drawer
 * yellow border, white bracket line with its draw request,
 * three channel override regions, all registered
 */
`default_nettype none

module backGroundDraw
#(
	parameter int hActive = vgaPkg::DEF_H_ACTIVE,
	parameter int vActive = vgaPkg::DEF_V_ACTIVE
)
(
	input logic clk,
	input logic resetN,
	input vgaPkg::pixelPos pos,
	output vgaPkg::rgbPixel bgColour,
	output logic borderDrawReq
);

	localparam logic [10:0] X_LAST = 11'(hActive - 1);
	localparam logic [10:0] Y_LAST = 11'(vActive - 1);
	localparam logic [10:0] BRACKET_OFFSET = 11'd1;

	// region corners follow the frame size
	localparam logic [10:0] RED_X = 11'(hActive / 4);
	localparam logic [10:0] RED_Y = 11'(vActive / 2);
	localparam logic [10:0] GREEN_X = 11'(hActive / 3);
	localparam logic [10:0] GREEN_Y = 11'((3 * vActive) / 4);
	localparam logic [10:0] BLUE_X = 11'(hActive / 2);
	localparam logic [10:0] BLUE_Y = 11'(vActive / 3);

	vgaPkg::rgbPixel colourNext;
	logic onBorder;
	logic onBracket;

	assign onBorder = (pos.x == 11'd0) || (pos.y == 11'd0) ||
		(pos.x == X_LAST) || (pos.y == Y_LAST);
	assign onBracket = (pos.x == BRACKET_OFFSET) || (pos.y == BRACKET_OFFSET) ||
		(pos.x == X_LAST - BRACKET_OFFSET) || (pos.y == Y_LAST - BRACKET_OFFSET);

	// later rules override earlier ones, channel by channel
	always_comb
	begin
		colourNext.fields.red = 3'b010; // greenish default
		colourNext.fields.green = 3'b110;
		colourNext.fields.blue = vgaPkg::LIGHT_COLOR[1:0];
		if (onBorder)
		begin
			colourNext.fields.red = vgaPkg::DARK_COLOR; // yellow
			colourNext.fields.green = vgaPkg::DARK_COLOR;
			colourNext.fields.blue = vgaPkg::LIGHT_COLOR[1:0];
		end
		if (onBracket)
			colourNext.raw = {vgaPkg::DARK_COLOR, vgaPkg::DARK_COLOR, vgaPkg::DARK_COLOR[1:0]};
		if ((pos.x > RED_X) && (pos.y >= RED_Y))
			colourNext.fields.red = vgaPkg::DARK_COLOR;
		if ((pos.x < GREEN_X) && (pos.y < GREEN_Y))
			colourNext.fields.green = 3'b011;
		if ((pos.x < BLUE_X) && (pos.y < BLUE_Y))
			colourNext.fields.blue = 2'b10;
	end

	always_ff @(posedge clk or negedge resetN)
	begin
		if (!resetN)
		begin
			bgColour.raw <= {vgaPkg::DARK_COLOR, vgaPkg::DARK_COLOR, vgaPkg::DARK_COLOR[1:0]};
			borderDrawReq <= 1'b0;
		end
		else
		begin
			bgColour <= colourNext;
			borderDrawReq <= onBracket; // request only on the bracket line
		end
	end

endmodule

`default_nettype wire

/* source/squareObject.sv */
/*
 * Moving square
 * left edge register stepped once per frame with wrap,
 * registered draw request and colour
 */
`default_nettype none

module squareObject
#(
	parameter int hActive = vgaPkg::DEF_H_ACTIVE,
	parameter int vActive = vgaPkg::DEF_V_ACTIVE,
	parameter int squareSize = 32,
	parameter int squareStep = 4
)
(
	input logic clk,
	input logic resetN,
	input vgaPkg::pixelPos pos,
	input logic startOfFrame,
	output logic squareDrawReq,
	output vgaPkg::rgbPixel squareColour
);

	localparam logic [11:0] SIZE = 12'(squareSize);
	localparam logic [11:0] STEP = 12'(squareStep);
	localparam logic [11:0] H_LIMIT = 12'(hActive);
	localparam logic [10:0] Y_TOP = 11'(vActive / 2);
	localparam logic [10:0] Y_BOTTOM = 11'(vActive / 2 + squareSize - 1);

	logic [10:0] leftX;
	logic firstFrame; // frame 0 keeps the square at the left edge
	logic [11:0] stepX; // one bit wider so the overrun test cannot wrap
	logic wrapX;
	logic inSquare;

	assign stepX = {1'b0, leftX} + STEP;
	assign wrapX = (stepX + SIZE) > H_LIMIT;

	always_ff @(posedge clk or negedge resetN)
	begin
		if (!resetN)
		begin
			leftX <= '0;
			firstFrame <= 1'b1;
		end
		else if (startOfFrame)
		begin
			firstFrame <= 1'b0;
			if (!firstFrame)
				leftX <= wrapX ? 11'd0 : stepX[10:0]; // new edge seen from next pixel on
		end
	end

	assign inSquare = (pos.x >= leftX) && ({1'b0, pos.x} < ({1'b0, leftX} + SIZE)) &&
		(pos.y >= Y_TOP) && (pos.y <= Y_BOTTOM);

	always_ff @(posedge clk or negedge resetN)
	begin
		if (!resetN)
		begin
			squareDrawReq <= 1'b0;
			squareColour <= '0;
		end
		else
		begin
			squareDrawReq <= inSquare;
			squareColour <= inSquare ? vgaPkg::SQUARE_COLOR : '0; // black off the square
		end
	end

endmodule

`default_nettype wire

/* source/objectsMux.sv */
/*
 * Object priority mux
 * square over background, blanking, collision pulse
 */
`default_nettype none

module objectsMux
(
	input logic clk,
	input logic resetN,
	input logic active,
	input logic squareDrawReq,
	input logic borderDrawReq,
	input vgaPkg::rgbPixel squareColour,
	input vgaPkg::rgbPixel bgColour,
	output vgaPkg::rgbPixel rgb,
	output logic collision
);

	logic activeD; // active lined up with the drawer outputs

	always_ff @(posedge clk or negedge resetN)
	begin
		if (!resetN)
		begin
			activeD <= 1'b0;
			rgb <= '0;
			collision <= 1'b0;
		end
		else
		begin
			activeD <= active;
			if (!activeD)
				rgb <= '0; // black while blanking
			else if (squareDrawReq)
				rgb <= squareColour;
			else
				rgb <= bgColour;
			// square touching the bracket line, visible pixels only
			collision <= activeD && squareDrawReq && borderDrawReq;
		end
	end

endmodule

`default_nettype wire

/* source/videoTop.sv */
/*
 * Video subsystem top level
 * sync generator, background, square and mux wired together
 */
`default_nettype none

module videoTop
#(
	parameter int hActive = vgaPkg::DEF_H_ACTIVE,
	parameter int hFront = vgaPkg::DEF_H_FRONT,
	parameter int hSync = vgaPkg::DEF_H_SYNC,
	parameter int hBack = vgaPkg::DEF_H_BACK,
	parameter int vActive = vgaPkg::DEF_V_ACTIVE,
	parameter int vFront = vgaPkg::DEF_V_FRONT,
	parameter int vSync = vgaPkg::DEF_V_SYNC,
	parameter int vBack = vgaPkg::DEF_V_BACK,
	parameter int squareSize = 32,
	parameter int squareStep = 4
)
(
	input logic clk,
	input logic resetN,
	output logic [7:0] rgb,
	output logic hSyncN,
	output logic vSyncN,
	output logic collision
);

	vgaPkg::pixelPos pos;
	logic active;
	logic startOfFrame;
	vgaPkg::rgbPixel bgColour;
	vgaPkg::rgbPixel squareColour;
	vgaPkg::rgbPixel rgbWord;
	logic borderDrawReq;
	logic squareDrawReq;

	vgaSyncGen #(
		.hActive(hActive), .hFront(hFront), .hSync(hSync), .hBack(hBack),
		.vActive(vActive), .vFront(vFront), .vSync(vSync), .vBack(vBack)
	) u_syncGen (
		.clk(clk), .resetN(resetN), .pos(pos), .active(active),
		.startOfFrame(startOfFrame), .hSyncN(hSyncN), .vSyncN(vSyncN)
	);

	backGroundDraw #(.hActive(hActive), .vActive(vActive)) u_backGround (
		.clk(clk), .resetN(resetN), .pos(pos),
		.bgColour(bgColour), .borderDrawReq(borderDrawReq)
	);

	squareObject #(
		.hActive(hActive), .vActive(vActive),
		.squareSize(squareSize), .squareStep(squareStep)
	) u_square (
		.clk(clk), .resetN(resetN), .pos(pos), .startOfFrame(startOfFrame),
		.squareDrawReq(squareDrawReq), .squareColour(squareColour)
	);

	objectsMux u_mux (
		.clk(clk), .resetN(resetN), .active(active),
		.squareDrawReq(squareDrawReq), .borderDrawReq(borderDrawReq),
		.squareColour(squareColour), .bgColour(bgColour),
		.rgb(rgbWord), .collision(collision)
	);

	assign rgb = rgbWord.raw; // raw byte view at the pins

endmodule

`default_nettype wire

/* verif/videoTop_props.sv */
/*
 * Bound checks for the video top level
 * sync pulse widths, collision only on visible pixels
 */
`default_nettype none

module videoTop_props
#(
	parameter int hSync = 4,
	parameter int vSync = 2,
	parameter int lineLength = 40
)
(
	input logic clk,
	input logic resetN,
	input logic active,
	input logic hSyncN,
	input logic vSyncN,
	input logic collision
);

	int hLow; // consecutive low clocks of each sync
	int vLow;
	logic activeD1;
	logic activeD2; // active lined up with rgb and collision

	always_ff @(posedge clk or negedge resetN)
	begin
		if (!resetN)
		begin
			hLow <= 0;
			vLow <= 0;
			activeD1 <= 1'b0;
			activeD2 <= 1'b0;
		end
		else
		begin
			hLow <= hSyncN ? 0 : hLow + 1;
			vLow <= vSyncN ? 0 : vLow + 1;
			activeD1 <= active;
			activeD2 <= activeD1;
		end
	end

	// horizontal pulse lasts hSync pixels
	hSyncWidth: assert property (@(posedge clk) disable iff (!resetN)
		$rose(hSyncN) |-> (hLow == hSync))
		else $error("hSyncN low for %0d clocks", hLow);

	// vertical pulse lasts vSync whole lines
	vSyncWidth: assert property (@(posedge clk) disable iff (!resetN)
		$rose(vSyncN) |-> (vLow == vSync * lineLength))
		else $error("vSyncN low for %0d clocks", vLow);

	noBlankCollision: assert property (@(posedge clk) disable iff (!resetN)
		collision |-> activeD2)
		else $error("collision raised during blanking");

endmodule

`default_nettype wire

/* verif/videoTop_tb.sv */
/*
 * Testbench for the video top level
 * clock, reset, raster model with reference colour function,
 * comparing process, check task and watchdog
 */
`default_nettype none

module videoTop_tb;

	localparam int CLK_PERIOD = 10;
	localparam int H_ACT = 32; // small test frame
	localparam int H_FP = 2;
	localparam int H_SY = 4;
	localparam int H_BP = 2;
	localparam int V_ACT = 24;
	localparam int V_FP = 2;
	localparam int V_SY = 2;
	localparam int V_BP = 2;
	localparam int SQ_SIZE = 4;
	localparam int SQ_STEP = 3;
	localparam int H_TOTAL = H_ACT + H_FP + H_SY + H_BP;
	localparam int V_TOTAL = V_ACT + V_FP + V_SY + V_BP;
	localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
	localparam int NUM_FRAMES = 12; // enough for the square to wrap once
	localparam int TIMEOUT = (NUM_FRAMES + 2) * FRAME_CYCLES * CLK_PERIOD;

	logic clk;
	logic resetN;
	logic [7:0] rgb;
	logic hSyncN;
	logic vSyncN;
	logic collision;

	int mx = 0; // raster model position of the pixel now at the outputs
	int my = 0;
	int frame = 0;
	int squareLeft = 0;
	int checkCount = 0;
	int errCount = 0;
	int wrapCount = 0; // later frames with the square seen back at x = 0
	int collisionsSeen = 0;
	logic simDone = 1'b0;

	videoTop #(
		.hActive(H_ACT), .hFront(H_FP), .hSync(H_SY), .hBack(H_BP),
		.vActive(V_ACT), .vFront(V_FP), .vSync(V_SY), .vBack(V_BP),
		.squareSize(SQ_SIZE), .squareStep(SQ_STEP)
	) u_dut (
		.clk(clk), .resetN(resetN), .rgb(rgb),
		.hSyncN(hSyncN), .vSyncN(vSyncN), .collision(collision)
	);

	bind videoTop videoTop_props #(
		.hSync(hSync), .vSync(vSync),
		.lineLength(hActive + hFront + hSync + hBack)
	) u_props (
		.clk(clk), .resetN(resetN), .active(active),
		.hSyncN(hSyncN), .vSyncN(vSyncN), .collision(collision)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	function automatic logic onBracket(input int x, input int y);
		return (x == 1) || (x == H_ACT - 2) || (y == 1) || (y == V_ACT - 2);
	endfunction

	function automatic logic onSquare(input int x, input int y, input int left);
		return (x >= left) && (x < left + SQ_SIZE) &&
			(y >= V_ACT / 2) && (y < V_ACT / 2 + SQ_SIZE);
	endfunction

	// left edge for the following frame, back to 0 on overrun
	function automatic int nextLeft(input int left);
		return (left + SQ_STEP + SQ_SIZE > H_ACT) ? 0 : left + SQ_STEP;
	endfunction

	// expected rgb byte for one pixel, drawing rules in order
	function automatic logic [7:0] refColour(input int x, input int y, input int left);
		logic [2:0] red;
		logic [2:0] green;
		logic [1:0] blue;
		if ((x >= H_ACT) || (y >= V_ACT))
			return 8'h00; // blanking
		if (onSquare(x, y, left))
			return vgaPkg::SQUARE_COLOR.raw;
		red = 3'd2;
		green = 3'd6;
		blue = 2'd0;
		if ((x == 0) || (x == H_ACT - 1) || (y == 0) || (y == V_ACT - 1))
		begin
			red = 3'd7; // yellow border
			green = 3'd7;
			blue = 2'd0;
		end
		if (onBracket(x, y))
		begin
			red = 3'd7;
			green = 3'd7;
			blue = 2'd3;
		end
		if ((x > H_ACT / 4) && (y >= V_ACT / 2))
			red = 3'd7;
		if ((x < H_ACT / 3) && (y < (3 * V_ACT) / 4))
			green = 3'd3;
		if ((x < H_ACT / 2) && (y < V_ACT / 3))
			blue = 2'd2;
		return {red, green, blue};
	endfunction

	task automatic compareValue(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checkCount++;
		if (got !== exp)
		begin
			errCount++;
			$display("ERR %s got 0x%0h expected 0x%0h at x=%0d y=%0d frame=%0d",
				name, got, exp, mx, my, frame);
		end
	endtask

	// outputs while reset or pipeline fill
	task automatic verifyIdle();
		compareValue("rgb", 32'(rgb), 32'h0);
		compareValue("collision", 32'(collision), 32'h0);
		compareValue("hSyncN", 32'(hSyncN), 32'h1);
		compareValue("vSyncN", 32'(vSyncN), 32'h1);
	endtask

	task automatic verifyPixel();
		logic expColl;
		logic expHSyncN;
		logic expVSyncN;
		expColl = (mx < H_ACT) && (my < V_ACT) && onSquare(mx, my, squareLeft) &&
			onBracket(mx, my);
		expHSyncN = !((mx >= H_ACT + H_FP) && (mx < H_ACT + H_FP + H_SY));
		expVSyncN = !((my >= V_ACT + V_FP) && (my < V_ACT + V_FP + V_SY));
		if (collision === 1'b1)
			collisionsSeen++;
		// square drawn at the left edge again after frame 0
		if ((frame > 0) && (mx == 0) && (my == V_ACT / 2) &&
			(rgb === vgaPkg::SQUARE_COLOR.raw))
			wrapCount++;
		compareValue("rgb", 32'(rgb), 32'(refColour(mx, my, squareLeft)));
		compareValue("collision", 32'(collision), 32'(expColl));
		compareValue("hSyncN", 32'(hSyncN), 32'(expHSyncN));
		compareValue("vSyncN", 32'(vSyncN), 32'(expVSyncN));
	endtask

	task automatic advanceRaster();
		mx++;
		if (mx == H_TOTAL)
		begin
			mx = 0;
			my++;
			if (my == V_TOTAL)
			begin
				my = 0;
				frame++;
				squareLeft = nextLeft(squareLeft);
			end
		end
	endtask

	// comparing process, samples on the falling edge
	initial
	begin
		@(negedge clk);
		while (resetN !== 1'b1)
		begin
			verifyIdle();
			@(negedge clk);
		end
		verifyIdle(); // two clocks of pipeline fill before pixel 0
		@(negedge clk);
		verifyIdle();
		@(negedge clk);
		while (frame < NUM_FRAMES)
		begin
			verifyPixel();
			advanceRaster();
			@(negedge clk);
		end
		simDone = 1'b1;
	end

	initial
	begin
		resetN = 1'b0;
		repeat (10) @(posedge clk);
		#1 resetN = 1'b1;
		wait (simDone);
		if (wrapCount == 0)
		begin
			errCount++;
			$display("the square was never seen back at the left edge");
		end
		if (collisionsSeen == 0)
		begin
			errCount++;
			$display("collision was never raised");
		end
		$display("checks %0d, errors %0d", checkCount, errCount);
		if (errCount == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

	// watchdog, a couple of frames beyond the planned run
	initial
	begin
		#(TIMEOUT);
		$display("timeout: raster did not finish %0d frames", NUM_FRAMES);
		$display("checks %0d, errors %0d", checkCount, errCount + 1);
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire

/* list.f */
source/vgaPkg.sv
source/vgaSyncGen.sv
source/backGroundDraw.sv
source/squareObject.sv
source/objectsMux.sv
source/videoTop.sv
verif/videoTop_props.sv
verif/videoTop_tb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS := --timing --assert
TOP := videoTop_tb
FILELIST := list.f
OBJ_DIR := obj_dir
LOG := sim.log
FAIL_MSG := FAIL: see errors above

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	cat $(LOG)
	! grep -q "$(FAIL_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
